// File: common/hit_result_if.sv
`timescale 1ns/10ps

interface hit_result_if;
    import raycast_pkg::*;

    // one result per clock when valid, no back-pressure
    logic valid;
    logic last;
    shape_addr_t addr;
    logic hit;
    dist_t key;

    modport source (
        output valid,
        output last,
        output addr,
        output hit,
        output key
    );

    modport sink (
        input valid,
        input last,
        input addr,
        input hit,
        input key
    );

endinterface

// File: common/raycast_pkg.sv
package raycast_pkg;

    // table size limits
    localparam int MAX_SHAPES = 16;
    localparam int ADDR_W = 4;

    // fixed-point widths
    localparam int COORD_W = 12;
    localparam int DIST_W = 28;
    localparam int PROD_W = 60;

    // cycles from a shape entering the hit test to its result
    localparam int HIT_LATENCY = 4;

    typedef logic signed [COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vec3_t;

    typedef logic [COORD_W-1:0] radius_t;
    typedef logic [ADDR_W-1:0] shape_addr_t;

    // squared distance to the sphere center, the ranking key
    typedef logic [DIST_W-1:0] dist_t;
    typedef logic signed [PROD_W-1:0] prod_t;

endpackage

// File: raycast.f
common/raycast_pkg.sv
common/hit_result_if.sv
raycast/raycast_fsm.sv
raycast/shape_addr_counter.sv
raycast/sphere_hit_pipe.sv
raycast/nearest_hit_select.sv
verilog/raycast_top.sv
verif/tb_clk_gen.sv
verif/raycast_sva.sv
verif/raycast_tb.sv

// File: raycast/nearest_hit_select.sv
`timescale 1ns/10ps

module nearest_hit_select (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    clear_i,
    hit_result_if.sink              res,
    output logic                    hit_o,
    output raycast_pkg::shape_addr_t best_addr_o,
    output raycast_pkg::dist_t       best_dist_o
);

    logic best_valid_q;
    logic [$bits(best_addr_o)-1:0] best_addr_q;
    logic [$bits(best_dist_o)-1:0] best_key_q;
    logic closer;
    logic take;

    // strictly nearer, or a tie that the lower address breaks
    assign closer = (res.key < best_key_q)
                 || ((res.key == best_key_q) && (res.addr < best_addr_q));

    assign take = res.valid && res.hit && (!best_valid_q || closer);

    always_ff @(posedge clk) begin
        if (rst) begin
            best_valid_q <= 1'b0;
        end else if (clear_i) begin
            best_valid_q <= 1'b0;
        end else if (take) begin
            best_valid_q <= 1'b1;
        end
    end

    // key and address only mean something once best_valid_q is set
    always_ff @(posedge clk) begin
        if (take && !clear_i) begin
            best_addr_q <= res.addr;
            best_key_q <= res.key;
        end
    end

    assign hit_o = best_valid_q;
    assign best_addr_o = best_addr_q;
    assign best_dist_o = best_key_q;

endmodule

// File: raycast/raycast_fsm.sv
`timescale 1ns/10ps

module raycast_fsm (
    input  logic       clk,
    input  logic       rst,
    input  logic       start_i,
    input  logic       cnt_last_i,
    hit_result_if.sink res,
    output logic       busy_o,
    output logic       capture_o,
    output logic       cnt_load_o,
    output logic       cnt_step_o,
    output logic       issue_o,
    output logic       done_o
);

    typedef enum logic [1:0] {
        IDLE,
        SENDING,
        WAITING,
        DONE
    } state_t;

    state_t state_q;
    state_t state_d;
    logic accept;

    // a start is only taken from idle, later ones are dropped
    assign accept = (state_q == IDLE) && start_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = SENDING;
                end
            end
            SENDING: begin
                // final shape goes out this cycle
                if (cnt_last_i) begin
                    state_d = WAITING;
                end
            end
            WAITING: begin
                if (res.valid && res.last) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign capture_o = accept;
    assign cnt_load_o = accept;
    assign issue_o = (state_q == SENDING);
    // hold the address on the last shape
    assign cnt_step_o = issue_o && !cnt_last_i;
    assign busy_o = (state_q != IDLE);
    assign done_o = (state_q == DONE);

endmodule

// File: raycast/shape_addr_counter.sv
`timescale 1ns/10ps

module shape_addr_counter #(
    parameter int NUM_SHAPES = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_i,
    input  logic                    step_i,
    output raycast_pkg::shape_addr_t addr_o,
    output logic                    last_o
);
    import raycast_pkg::*;

    localparam shape_addr_t LAST_ADDR = shape_addr_t'(NUM_SHAPES - 1);

    shape_addr_t addr_q;

    // load wins over step, a new search always starts at shape 0
    always_ff @(posedge clk) begin
        if (rst) begin
            addr_q <= '0;
        end else if (load_i) begin
            addr_q <= '0;
        end else if (step_i) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    assign addr_o = addr_q;

    // tags the final shape of the table
    assign last_o = (addr_q == LAST_ADDR);

endmodule

// File: raycast/sphere_hit_pipe.sv
`timescale 1ns/10ps

module sphere_hit_pipe (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid_i,
    input  logic                    last_i,
    input  raycast_pkg::shape_addr_t addr_i,
    input  raycast_pkg::vec3_t       ray_src_i,
    input  raycast_pkg::vec3_t       ray_dir_i,
    input  logic                    shape_on_i,
    input  raycast_pkg::vec3_t       center_i,
    input  raycast_pkg::radius_t     radius_i,
    hit_result_if.source            res
);
    import raycast_pkg::*;

    // stage 1: offset from ray source to sphere center
    logic signed [COORD_W:0] s1_l [3];
    radius_t s1_radius;
    logic s1_on;
    logic s1_valid;
    logic s1_last;
    shape_addr_t s1_addr;

    // stage 2: dot products and squared radius
    dist_t s2_ll;
    prod_t s2_dd;
    prod_t s2_tca;
    prod_t s2_rr;
    logic s2_on;
    logic s2_valid;
    logic s2_last;
    shape_addr_t s2_addr;

    // stage 3: squared perpendicular distance vs radius, both scaled by d.d
    prod_t s3_lhs;
    prod_t s3_rhs;
    logic s3_front;
    dist_t s3_key;
    logic s3_on;
    logic s3_valid;
    logic s3_last;
    shape_addr_t s3_addr;

    always_ff @(posedge clk) begin
        s1_l[0] <= (COORD_W+1)'(center_i.x) - (COORD_W+1)'(ray_src_i.x);
        s1_l[1] <= (COORD_W+1)'(center_i.y) - (COORD_W+1)'(ray_src_i.y);
        s1_l[2] <= (COORD_W+1)'(center_i.z) - (COORD_W+1)'(ray_src_i.z);
        s1_radius <= radius_i;
        s1_on <= shape_on_i;
        s1_last <= last_i;
        s1_addr <= addr_i;

        // ray is held by the top for the whole search
        s2_ll <= dist_t'(prod_t'(s1_l[0]) * prod_t'(s1_l[0])
                       + prod_t'(s1_l[1]) * prod_t'(s1_l[1])
                       + prod_t'(s1_l[2]) * prod_t'(s1_l[2]));
        s2_dd <= prod_t'(ray_dir_i.x) * prod_t'(ray_dir_i.x)
               + prod_t'(ray_dir_i.y) * prod_t'(ray_dir_i.y)
               + prod_t'(ray_dir_i.z) * prod_t'(ray_dir_i.z);
        s2_tca <= prod_t'(s1_l[0]) * prod_t'(ray_dir_i.x)
                + prod_t'(s1_l[1]) * prod_t'(ray_dir_i.y)
                + prod_t'(s1_l[2]) * prod_t'(ray_dir_i.z);
        s2_rr <= prod_t'(s1_radius) * prod_t'(s1_radius);
        s2_on <= s1_on;
        s2_last <= s1_last;
        s2_addr <= s1_addr;

        // never negative by Cauchy-Schwarz
        s3_lhs <= prod_t'(s2_ll) * s2_dd - s2_tca * s2_tca;
        s3_rhs <= s2_rr * s2_dd;
        // center must lie ahead of the source
        s3_front <= (s2_tca > 0);
        s3_key <= s2_ll;
        s3_on <= s2_on;
        s3_last <= s2_last;
        s3_addr <= s2_addr;

        res.hit <= s3_on && s3_front && (s3_lhs <= s3_rhs);
        res.key <= s3_key;
        res.last <= s3_last;
        res.addr <= s3_addr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            res.valid <= 1'b0;
        end else begin
            s1_valid <= valid_i;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
            res.valid <= s3_valid;
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the raycast testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module raycast_tb \
    -Mdir "$OBJ_DIR" \
    -f raycast.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/Vraycast_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: verif/raycast_sva.sv
`timescale 1ns/10ps

module raycast_sva (
    input logic                     clk,
    input logic                     rst,
    input logic                     busy_i,
    input logic                     done_i,
    input raycast_pkg::shape_addr_t shape_addr_i
);

    // done is a single-cycle strobe
    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done_i |=> !done_i)
        else $error("done_o stayed high for more than one cycle");

    a_done_busy: assert property (@(posedge clk) disable iff (rst) done_i |-> busy_i)
        else $error("done_o pulsed while busy_o was low");

    a_idle_after_reset: assert property (@(posedge clk) rst |=> !busy_i)
        else $error("busy_o was high in the cycle after reset");

    // the counter only moves during a search
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        !busy_i |-> $stable(shape_addr_i))
        else $error("shape_addr_o changed while the design was idle");

endmodule

bind raycast_top raycast_sva raycast_sva_inst (
    .clk          (clk),
    .rst          (rst),
    .busy_i       (busy_o),
    .done_i       (done_o),
    .shape_addr_i (shape_addr_o)
);

// File: verif/raycast_tb.sv
`timescale 1ns/10ps

module raycast_tb;
    import raycast_pkg::*;

    localparam int NUM_SHAPES = 8;
    localparam int NUM_RANDOM = 200;
    localparam int NUM_TIMING = 4;
    // random and timing rays, three directed rays, two back to back
    localparam int NUM_RAYS = NUM_RANDOM + NUM_TIMING + 5;
    localparam int SEARCH_CYCLES = NUM_SHAPES + HIT_LATENCY + 1;
    localparam int MAX_CYCLES = NUM_RAYS * (NUM_SHAPES + HIT_LATENCY + 4) + 100;

    logic clk;
    logic rst;
    logic start;
    vec3_t ray_src;
    vec3_t ray_dir;
    shape_addr_t shape_addr;
    logic shape_on;
    vec3_t shape_center;
    radius_t shape_radius;
    logic busy;
    logic done;
    logic hit;
    shape_addr_t best_addr;
    dist_t best_dist;

    // shape table outside the DUT
    logic tbl_on [MAX_SHAPES];
    vec3_t tbl_center [MAX_SHAPES];
    radius_t tbl_radius [MAX_SHAPES];

    int seed;
    int n_checks;
    int n_errors;
    int errs_before;
    int cycle_cnt = 0;
    int lat;
    bit m_hit;
    longint m_addr;
    longint m_dist;
    vec3_t rs;
    vec3_t rd;

    tb_clk_gen #(.PERIOD(100)) tb_clk_gen_inst (.clk_o(clk));

    assign shape_on = tbl_on[shape_addr];
    assign shape_center = tbl_center[shape_addr];
    assign shape_radius = tbl_radius[shape_addr];

    raycast_top #(
        .NUM_SHAPES (NUM_SHAPES)
    ) raycast_top_inst (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start),
        .ray_src_i      (ray_src),
        .ray_dir_i      (ray_dir),
        .shape_addr_o   (shape_addr),
        .shape_on_i     (shape_on),
        .shape_center_i (shape_center),
        .shape_radius_i (shape_radius),
        .busy_o         (busy),
        .done_o         (done),
        .hit_o          (hit),
        .best_addr_o    (best_addr),
        .best_dist_o    (best_dist)
    );

    function automatic vec3_t mk_vec(input int x, input int y, input int z);
        vec3_t v;
        v.x = coord_t'(x);
        v.y = coord_t'(y);
        v.z = coord_t'(z);
        return v;
    endfunction

    // components in -(span-1) .. span-1
    function automatic vec3_t rand_vec(input int span);
        vec3_t v;
        v.x = coord_t'($random(seed) % span);
        v.y = coord_t'($random(seed) % span);
        v.z = coord_t'($random(seed) % span);
        return v;
    endfunction

    task automatic set_shape(input int idx, input logic on, input vec3_t c, input int r);
        tbl_on[idx] = on;
        tbl_center[idx] = c;
        tbl_radius[idx] = radius_t'(r);
    endtask

    task automatic fill_table(input logic on, input vec3_t c, input int r);
        int i;
        for (i = 0; i < MAX_SHAPES; i++) begin
            set_shape(i, on, c, r);
        end
    endtask

    // small coordinates so that hits are common
    task automatic random_scene();
        int i;
        for (i = 0; i < MAX_SHAPES; i++) begin
            set_shape(i, ($random(seed) % 4) != 0, rand_vec(21), 1 + {$random(seed)} % 10);
        end
        rs = rand_vec(21);
        rd = rand_vec(9);
    endtask

    task automatic model_search(input vec3_t src, input vec3_t dir);
        int i;
        longint lx, ly, lz, dx, dy, dz, ll, dd, tca, rr;
        m_hit = 1'b0;
        m_addr = 0;
        m_dist = 0;
        dx = longint'(dir.x);
        dy = longint'(dir.y);
        dz = longint'(dir.z);
        dd = dx * dx + dy * dy + dz * dz;
        for (i = 0; i < NUM_SHAPES; i++) begin
            lx = longint'(tbl_center[i].x) - longint'(src.x);
            ly = longint'(tbl_center[i].y) - longint'(src.y);
            lz = longint'(tbl_center[i].z) - longint'(src.z);
            ll = lx * lx + ly * ly + lz * lz;
            tca = lx * dx + ly * dy + lz * dz;
            rr = longint'(tbl_radius[i]) * longint'(tbl_radius[i]);
            // enabled, ahead of the source, and no farther off the line than r
            if (tbl_on[i] && tca > 0 && ll * dd - tca * tca <= rr * dd) begin
                if (!m_hit || ll < m_dist || (ll == m_dist && i < m_addr)) begin
                    m_hit = 1'b1;
                    m_addr = i;
                    m_dist = ll;
                end
            end
        end
    endtask

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_result(input string what);
        check(64'(hit), 64'(m_hit), {what, " hit"});
        if (m_hit) begin
            check(64'(best_addr), m_addr, {what, " best_addr"});
            check(64'(best_dist), m_dist, {what, " best_dist"});
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // called 1 ns after a rising edge, returns at the falling edge where done is high
    task automatic run_ray(input vec3_t src, input vec3_t dir, input bit noisy);
        bit done_seen;
        done_seen = 1'b0;
        check(64'(busy), 64'd0, "busy before start");
        ray_src = src;
        ray_dir = dir;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        lat = 0;
        while (!done_seen) begin
            @(negedge clk);
            lat++;
            check(64'(busy), 64'd1, "busy during search");
            if (done) begin
                done_seen = 1'b1;
            end else begin
                next_cycle();
                // stray starts and a changing ray while the search runs
                if (noisy && lat < NUM_SHAPES + HIT_LATENCY) begin
                    start = ($random(seed) % 2) != 0;
                    ray_src = rand_vec(21);
                    ray_dir = rand_vec(9);
                end else begin
                    start = 1'b0;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the search did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        seed = 32'h1eb6_4c35;
        n_checks = 0;
        n_errors = 0;
        rst = 1'b1;
        start = 1'b0;
        ray_src = '0;
        ray_dir = '0;
        fill_table(1'b0, mk_vec(0, 0, 0), 0);
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        errs_before = n_errors;
        for (int r = 0; r < NUM_RANDOM; r++) begin
            next_cycle();
            random_scene();
            model_search(rs, rd);
            run_ray(rs, rd, 1'b0);
            check_result("random scene");
        end
        $display("test random scenes: %0d rays, %0d errors", NUM_RANDOM, n_errors - errs_before);

        errs_before = n_errors;
        for (int r = 0; r < NUM_TIMING; r++) begin
            next_cycle();
            random_scene();
            model_search(rs, rd);
            run_ray(rs, rd, 1'b1);
            check(64'(lat), 64'(SEARCH_CYCLES), "done latency");
            check_result("ignored start");
        end
        $display("test timing and ignored starts: %0d errors", n_errors - errs_before);

        // even slots behind the source, odd slots far off the line
        errs_before = n_errors;
        next_cycle();
        for (int i = 0; i < MAX_SHAPES; i++) begin
            if (i % 2 == 0) begin
                set_shape(i, 1'b1, mk_vec(-4 * i - 4, -2 * i, 0), 3);
            end else begin
                set_shape(i, 1'b1, mk_vec(5 * i, 40, 3), 2);
            end
        end
        run_ray(mk_vec(0, 0, 0), mk_vec(2, 1, 0), 1'b0);
        check(64'(hit), 64'd0, "behind or off line hit");
        $display("test misses: %0d errors", n_errors - errs_before);

        // nearer shapes 0 and 2 are switched off
        errs_before = n_errors;
        next_cycle();
        fill_table(1'b1, mk_vec(-30, 0, 0), 2);
        set_shape(0, 1'b0, mk_vec(5, 0, 0), 3);
        set_shape(1, 1'b1, mk_vec(20, 0, 0), 3);
        set_shape(2, 1'b0, mk_vec(3, 0, 0), 3);
        set_shape(3, 1'b1, mk_vec(12, 1, 0), 3);
        run_ray(mk_vec(0, 0, 0), mk_vec(1, 0, 0), 1'b0);
        check(64'(hit), 64'd1, "disabled shapes hit");
        check(64'(best_addr), 64'd3, "disabled shapes best_addr");
        check(64'(best_dist), 64'd145, "disabled shapes best_dist");
        $display("test disabled shapes: %0d errors", n_errors - errs_before);

        // shapes 2 and 5 sit at the same distance
        errs_before = n_errors;
        next_cycle();
        fill_table(1'b1, mk_vec(-30, -30, 0), 2);
        set_shape(2, 1'b1, mk_vec(10, 0, 0), 8);
        set_shape(5, 1'b1, mk_vec(0, 10, 0), 8);
        set_shape(6, 1'b1, mk_vec(20, 20, 0), 3);
        run_ray(mk_vec(0, 0, 0), mk_vec(1, 1, 0), 1'b0);
        check(64'(hit), 64'd1, "equal keys hit");
        check(64'(best_addr), 64'd2, "equal keys best_addr");
        check(64'(best_dist), 64'd100, "equal keys best_dist");
        $display("test equal keys: %0d errors", n_errors - errs_before);

        // second start lands in the cycle right after done
        errs_before = n_errors;
        for (int r = 0; r < 2; r++) begin
            next_cycle();
            random_scene();
            model_search(rs, rd);
            run_ray(rs, rd, 1'b0);
            check(64'(lat), 64'(SEARCH_CYCLES), "back to back latency");
            check_result("back to back");
        end
        $display("test back to back starts: %0d errors", n_errors - errs_before);

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    // half period high, half period low
    always begin
        #(PERIOD / 2);
        clk_o = ~clk_o;
    end

endmodule

// File: verilog/raycast_top.sv
`timescale 1ns/10ps

module raycast_top #(
    parameter int NUM_SHAPES = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start_i,
    input  raycast_pkg::vec3_t       ray_src_i,
    input  raycast_pkg::vec3_t       ray_dir_i,
    output raycast_pkg::shape_addr_t shape_addr_o,
    input  logic                    shape_on_i,
    input  raycast_pkg::vec3_t       shape_center_i,
    input  raycast_pkg::radius_t     shape_radius_i,
    output logic                    busy_o,
    output logic                    done_o,
    output logic                    hit_o,
    output raycast_pkg::shape_addr_t best_addr_o,
    output raycast_pkg::dist_t       best_dist_o
);
    import raycast_pkg::*;

    if (NUM_SHAPES < 1 || NUM_SHAPES > MAX_SHAPES) begin : g_bad_num_shapes
        $error("NUM_SHAPES must be between 1 and MAX_SHAPES");
    end

    vec3_t ray_src_q;
    vec3_t ray_dir_q;
    shape_addr_t cnt_addr;
    logic capture;
    logic cnt_load;
    logic cnt_step;
    logic cnt_last;
    logic issue;

    hit_result_if res_if ();

    // ray stays fixed from capture until the next accepted start
    always_ff @(posedge clk) begin
        if (capture) begin
            ray_src_q <= ray_src_i;
            ray_dir_q <= ray_dir_i;
        end
    end

    raycast_fsm raycast_fsm_inst (
        .clk        (clk),
        .rst        (rst),
        .start_i    (start_i),
        .cnt_last_i (cnt_last),
        .res        (res_if.sink),
        .busy_o     (busy_o),
        .capture_o  (capture),
        .cnt_load_o (cnt_load),
        .cnt_step_o (cnt_step),
        .issue_o    (issue),
        .done_o     (done_o)
    );

    shape_addr_counter #(
        .NUM_SHAPES (NUM_SHAPES)
    ) shape_addr_counter_inst (
        .clk    (clk),
        .rst    (rst),
        .load_i (cnt_load),
        .step_i (cnt_step),
        .addr_o (cnt_addr),
        .last_o (cnt_last)
    );

    // table answers in the same cycle as the address
    assign shape_addr_o = cnt_addr;

    sphere_hit_pipe sphere_hit_pipe_inst (
        .clk        (clk),
        .rst        (rst),
        .valid_i    (issue),
        .last_i     (cnt_last),
        .addr_i     (cnt_addr),
        .ray_src_i  (ray_src_q),
        .ray_dir_i  (ray_dir_q),
        .shape_on_i (shape_on_i),
        .center_i   (shape_center_i),
        .radius_i   (shape_radius_i),
        .res        (res_if.source)
    );

    nearest_hit_select nearest_hit_select_inst (
        .clk         (clk),
        .rst         (rst),
        .clear_i     (capture),
        .res         (res_if.sink),
        .hit_o       (hit_o),
        .best_addr_o (best_addr_o),
        .best_dist_o (best_dist_o)
    );

endmodule
